//--- design/adderPkg.sv
package adderPkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// operand width, must be a power of two
	localparam int defaultWidth = 32;

	////////////////////////////////////////
	// state machines
	////////////////////////////////////////

	// request side, one transaction in flight at a time
	typedef enum logic [1:0] {
		idle,
		busy,
		releasing
	} decodeState;

	// ack side of the four-phase handshake
	typedef enum logic {
		waiting,
		acked
	} resultState;

endpackage

//--- design/prefixBus.sv
`timescale 1ns/10ps

interface prefixBus #(
	parameter int dataWidth = adderPkg::defaultWidth
);

	typedef logic [dataWidth-1:0] pgWord;

	// one-cycle pulse per transaction
	logic  valid;
	pgWord propagate;
	// bitwise or group generates, depending on the stage
	pgWord gen;
	logic  carryIn;

	modport source (
		output valid,
		output propagate,
		output gen,
		output carryIn
	);

	modport sink (
		input valid,
		input propagate,
		input gen,
		input carryIn
	);

endinterface

//--- design/operandDecode.sv
`timescale 1ns/10ps

module operandDecode #(
	parameter int dataWidth = adderPkg::defaultWidth
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic                 carryIn,
	input  logic                 ack,
	prefixBus.source             decodeBus
);

	typedef logic [dataWidth-1:0] operandWord;

	adderPkg::decodeState state;
	operandWord           bitGen;

	////////////////////////////////////////
	// bitwise generate
	////////////////////////////////////////

	// carry-in folded into bit 0, so group generate i is the carry out of bit i
	always_comb begin
		bitGen    = a & b;
		bitGen[0] = (a[0] & b[0]) | ((a[0] ^ b[0]) & carryIn);
	end

	////////////////////////////////////////
	// request FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= adderPkg::idle;
			decodeBus.valid <= 1'b0;
		end else begin
			decodeBus.valid <= 1'b0;
			case (state)
				adderPkg::idle: begin
					if (req) begin
						decodeBus.valid <= 1'b1;
						state           <= adderPkg::busy;
					end
				end
				adderPkg::busy: begin
					// result is out, wait for the requester to see it
					if (ack) begin
						state <= adderPkg::releasing;
					end
				end
				adderPkg::releasing: begin
					if (!ack) begin
						state <= adderPkg::idle;
					end
				end
				default: begin
					state <= adderPkg::idle;
				end
			endcase
		end
	end

	// operands are stable while req is high
	always_ff @(posedge clk) begin
		if (state == adderPkg::idle && req) begin
			decodeBus.propagate <= a ^ b;
			decodeBus.gen       <= bitGen;
			decodeBus.carryIn   <= carryIn;
		end
	end

	// a new request only starts once the previous ack has dropped
	validFromIdle: assert property (@(posedge clk) disable iff (reset)
		decodeBus.valid |-> $past(state == adderPkg::idle && req && !ack));

endmodule

//--- design/prefixTree.sv
`timescale 1ns/10ps

module prefixTree #(
	parameter int dataWidth = adderPkg::defaultWidth
) (
	input  logic     clk,
	input  logic     reset,
	prefixBus.sink   decodeBus,
	prefixBus.source carryBus
);

	typedef logic [dataWidth-1:0] groupWord;

	// pair level plus sklansky levels over the odd positions
	localparam int levels = $clog2(dataWidth);

	// one extra generate level for the final even fill
	groupWord groupGen [levels+2];
	groupWord groupProp [levels+1];

	assign groupGen[0]  = decodeBus.gen;
	assign groupProp[0] = decodeBus.propagate;

	////////////////////////////////////////
	// odd positions
	////////////////////////////////////////

	for (genvar lvl = 1; lvl <= levels; lvl++) begin : gLevel
		if (lvl == 1) begin : gPairs
			// adjacent pairs, bit 1 is a gray cell since its group reaches bit 0
			always_comb begin
				groupGen[lvl]  = groupGen[lvl-1];
				groupProp[lvl] = groupProp[lvl-1];
				for (int i = 1; i < dataWidth; i += 2) begin
					groupGen[lvl][i] = groupGen[lvl-1][i]
						| (groupProp[lvl-1][i] & groupGen[lvl-1][i-1]);
					if (i > 1) begin
						groupProp[lvl][i] = groupProp[lvl-1][i] & groupProp[lvl-1][i-1];
					end
				end
			end
		end else begin : gSklansky
			// block size in pair units
			localparam int span = 1 << (lvl - 2);

			always_comb begin
				int pair;
				int low;
				groupGen[lvl]  = groupGen[lvl-1];
				groupProp[lvl] = groupProp[lvl-1];
				for (int i = 1; i < dataWidth; i += 2) begin
					pair = i >> 1;
					if ((pair & span) != 0) begin
						// top odd position of the lower block
						low = 2 * ((pair & ~(span - 1)) - 1) + 1;
						groupGen[lvl][i] = groupGen[lvl-1][i]
							| (groupProp[lvl-1][i] & groupGen[lvl-1][low]);
						// black cell only while the group stays clear of bit 0
						if (pair >= 2 * span) begin
							groupProp[lvl][i] = groupProp[lvl-1][i] & groupProp[lvl-1][low];
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// even positions, gray cells
	////////////////////////////////////////

	always_comb begin
		groupGen[levels+1] = groupGen[levels];
		for (int i = 2; i < dataWidth; i += 2) begin
			groupGen[levels+1][i] = groupGen[levels][i]
				| (groupProp[levels][i] & groupGen[levels][i-1]);
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			carryBus.valid <= 1'b0;
		end else begin
			carryBus.valid <= decodeBus.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (decodeBus.valid) begin
			carryBus.gen       <= groupGen[levels+1];
			carryBus.propagate <= decodeBus.propagate;
			carryBus.carryIn   <= decodeBus.carryIn;
		end
	end

	// each registered carry obeys the ripple recurrence on the decoded bits
	for (genvar i = 1; i < dataWidth; i++) begin : gRippleCheck
		carryFollowsDecode: assert property (@(posedge clk) disable iff (reset)
			decodeBus.valid |=> carryBus.valid
				&& carryBus.gen[i] == ($past(decodeBus.gen[i])
					| (carryBus.propagate[i] & carryBus.gen[i-1])));
	end

endmodule

//--- design/sumResult.sv
`timescale 1ns/10ps

module sumResult #(
	parameter int dataWidth = adderPkg::defaultWidth
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	prefixBus.sink               carryBus,
	output logic                 ack,
	output logic [dataWidth-1:0] sum,
	output logic                 carryOut
);

	typedef logic [dataWidth-1:0] sumWord;

	adderPkg::resultState state;
	sumWord               carryInto;

	// carry into bit i is the group generate of bit i-1
	assign carryInto = {carryBus.gen[dataWidth-2:0], carryBus.carryIn};

	////////////////////////////////////////
	// ack control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= adderPkg::waiting;
		end else begin
			case (state)
				adderPkg::waiting: begin
					if (carryBus.valid) begin
						state <= adderPkg::acked;
					end
				end
				adderPkg::acked: begin
					// hold until the requester lets go
					if (!req) begin
						state <= adderPkg::waiting;
					end
				end
				default: begin
					state <= adderPkg::waiting;
				end
			endcase
		end
	end

	assign ack = (state == adderPkg::acked);

	// result register
	always_ff @(posedge clk) begin
		if (state == adderPkg::waiting && carryBus.valid) begin
			sum      <= carryBus.propagate ^ carryInto;
			carryOut <= carryBus.gen[dataWidth-1];
		end
	end

	sumHeldUnderAck: assert property (@(posedge clk) disable iff (reset)
		(ack && req) |=> ack && $stable(sum) && $stable(carryOut));

endmodule

//--- design/prefixAdderTop.sv
`timescale 1ns/10ps

module prefixAdderTop #(
	parameter int dataWidth = adderPkg::defaultWidth
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic                 carryIn,
	output logic                 ack,
	output logic [dataWidth-1:0] sum,
	output logic                 carryOut
);

	prefixBus #(.dataWidth(dataWidth)) decodeBus ();
	prefixBus #(.dataWidth(dataWidth)) carryBus ();

	////////////////////////////////////////
	// decode, tree, result
	////////////////////////////////////////

	operandDecode #(.dataWidth(dataWidth)) decodeStage (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.a         (a),
		.b         (b),
		.carryIn   (carryIn),
		.ack       (ack),
		.decodeBus (decodeBus)
	);

	prefixTree #(.dataWidth(dataWidth)) treeStage (
		.clk       (clk),
		.reset     (reset),
		.decodeBus (decodeBus),
		.carryBus  (carryBus)
	);

	sumResult #(.dataWidth(dataWidth)) resultStage (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.carryBus (carryBus),
		.ack      (ack),
		.sum      (sum),
		.carryOut (carryOut)
	);

endmodule

//--- verif/prefixAdderTb.sv
`timescale 1ns/10ps

module prefixAdderTb;

	localparam int width = adderPkg::defaultWidth;
	localparam int randomCount = 500;
	localparam int cornerCount = 10;
	localparam int maxHold = 8;
	// three for latency, the longest hold, two for release
	localparam int worstCycles = 3 + maxHold + 2;
	localparam int cycleLimit = (randomCount + cornerCount) * worstCycles + 100;
	localparam int ackWaitLimit = 10;

	logic             clk;
	logic             reset;
	logic             req;
	logic [width-1:0] a;
	logic [width-1:0] b;
	logic             carryIn;
	logic             ack;
	logic [width-1:0] sum;
	logic             carryOut;

	integer seed;
	int     passCount;
	int     failCount;
	int     cycleCount;
	int     testPass;
	int     testFail;

	prefixAdderTop UUT (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.a        (a),
		.b        (b),
		.carryIn  (carryIn),
		.ack      (ack),
		.sum      (sum),
		.carryOut (carryOut)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("run stopped after %0d cycles without finishing the tests", cycleCount);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////

	task automatic compareValue(input string name, input logic [width:0] expected,
			input logic [width:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %h, actual %h", name, expected, actual);
			failCount++;
		end else begin
			passCount++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("handshake failure at %0t: %s", $time, what);
		failCount++;
	endtask

	function automatic logic [width-1:0] randomWord();
		logic [width-1:0] w;
		w = '0;
		for (int i = 0; i < width; i += 32) begin
			w = {w, 32'($random(seed))};
		end
		return w;
	endfunction

	task automatic startTest();
		testPass = passCount;
		testFail = failCount;
	endtask

	task automatic finishTest(input string name);
		$display("test %s done: %0d checks, %0d errors", name,
			(passCount - testPass) + (failCount - testFail), failCount - testFail);
	endtask

	////////////////////////////////////////
	// one four-phase transaction
	////////////////////////////////////////

	task automatic runTransaction(input logic [width-1:0] opA, input logic [width-1:0] opB,
			input logic cin, input int hold);
		logic [width:0]   expected;
		logic [width-1:0] heldSum;
		logic             heldCarry;
		int               edges;
		// full-width reference sum
		expected = {1'b0, opA} + {1'b0, opB} + cin;
		a = opA;
		b = opB;
		carryIn = cin;
		req = 1'b1;
		edges = 0;
		while (!ack && edges < ackWaitLimit) begin
			@(posedge clk);
			#1;
			edges++;
		end
		if (!ack) begin
			reportFailure("ack never rose after req was raised");
			req = 1'b0;
			repeat (4) @(posedge clk);
			#1;
			return;
		end
		compareValue("ackLatency", 3, edges);
		compareValue("sum", expected[width-1:0], sum);
		compareValue("carryOut", expected[width], carryOut);
		heldSum = sum;
		heldCarry = carryOut;
		// requester keeps req high, result must not move
		repeat (hold) begin
			@(posedge clk);
			#1;
			compareValue("ack", 1, ack);
			compareValue("sum", heldSum, sum);
			compareValue("carryOut", heldCarry, carryOut);
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		if (ack) begin
			reportFailure("ack still high on the edge that sampled req low");
		end else begin
			passCount++;
		end
		// decode FSM needs one more edge to get back to idle
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [width-1:0] altA;
		logic [width-1:0] altB;
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		a = '0;
		b = '0;
		carryIn = 1'b0;
		seed = 1739;
		passCount = 0;
		failCount = 0;
		cycleCount = 0;
		altA = {(width / 2){2'b10}};
		altB = {(width / 2){2'b01}};

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// ack quiet until the first req
		startTest();
		repeat (4) begin
			@(posedge clk);
			#1;
			compareValue("ack", 0, ack);
		end
		finishTest("reset");

		startTest();
		for (int n = 0; n < randomCount; n++) begin
			runTransaction(randomWord(), randomWord(), $random(seed) & 1,
				{$random(seed)} % (maxHold + 1));
		end
		finishTest("random");

		// shortest and longest hold on the corner operands
		startTest();
		for (int c = 0; c < 2; c++) begin
			runTransaction('1, '0, c[0], c * maxHold);
			runTransaction('0, '0, c[0], c * maxHold);
			runTransaction(altA, altB, c[0], c * maxHold);
			runTransaction(altA, altA, c[0], c * maxHold);
			runTransaction('1, '1, c[0], c * maxHold);
		end
		finishTest("corner");

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
design/adderPkg.sv
design/prefixBus.sv
design/operandDecode.sv
design/prefixTree.sv
design/sumResult.sv
design/prefixAdderTop.sv
verif/prefixAdderTb.sv

//--- Bender.yml
package:
  name: prefix_adder

sources:
  - design/adderPkg.sv
  - design/prefixBus.sv
  - design/operandDecode.sv
  - design/prefixTree.sv
  - design/sumResult.sv
  - design/prefixAdderTop.sv
  - target: test
    files:
      - verif/prefixAdderTb.sv
